//--- hdl/tlk_link_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared constants and enums for the TLK2711 receive-side link checker
// word encodings of the transmit test frame, counter widths, error codes
////////////////////////////////////////////////////////////////////////////

package tlk_link_pkg;

    localparam int WORD_W = 16;
    localparam int CNT_W  = 16;

    // K-coded words, see k flags in the checker
    localparam logic [WORD_W-1:0] SYNC_WORD = 16'hC5BC;
    localparam logic [WORD_W-1:0] SOF_WORD  = 16'h5CFB;
    localparam logic [WORD_W-1:0] EOF_WORD  = 16'hFDFE;

    // plain data words of the frame header
    localparam logic [WORD_W-1:0] HEAD0_WORD   = 16'hEB90;
    localparam logic [WORD_W-1:0] HEAD1_WORD   = 16'hE116;
    localparam logic [WORD_W-1:0] FILEEND_WORD = 16'h8101;

    localparam logic [WORD_W-1:0] MAX_LEN_BYTES = 16'd1024;

    typedef enum logic [3:0] {
        ERR_NONE      = 4'd0,
        ERR_SYNC      = 4'd1,
        ERR_SOF       = 4'd2,
        ERR_HEAD0     = 4'd3,
        ERR_HEAD1     = 4'd4,
        ERR_FILEEND   = 4'd5,
        ERR_FRAME_CNT = 4'd6,
        ERR_LENGTH    = 4'd7,
        ERR_DATA      = 4'd8,
        ERR_CHECKSUM  = 4'd9,
        ERR_EOF       = 4'd10
    } err_code_e;

    // one state per frame field
    typedef enum logic [3:0] {
        HUNT, GAP, HEAD0, HEAD1, FILEEND,
        FRAME_CNT, LENGTH, DATA, CHECKSUM, EOF
    } chk_state_e;

endpackage

//--- hdl/tlk_rx_word_if.sv
////////////////////////////////////////////////////////////////////////////
// links inside the link checker: received words and checker events
// both carry single-cycle strobes with no back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface tlk_rx_word_if;
    import tlk_link_pkg::*;

    logic              valid;
    logic [WORD_W-1:0] data;
    logic              k_msb;
    logic              k_lsb;

    modport src (output valid, data, k_msb, k_lsb);
    modport dst (input valid, data, k_msb, k_lsb);
endinterface

interface tlk_chk_event_if;
    import tlk_link_pkg::*;

    logic              ev_valid;
    err_code_e         ev_code;
    logic              frame_ok;
    logic [WORD_W-1:0] frame_num;

    modport src (output ev_valid, ev_code, frame_ok, frame_num);
    modport dst (input ev_valid, ev_code, frame_ok, frame_num);
endinterface

//--- hdl/tlk_rx_capture.sv
////////////////////////////////////////////////////////////////////////////
// input stage of the link checker
// registers the SerDes word and K flags, qualifies them with check enable
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_rx_capture (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_soft_rst,
    input  logic                            i_check_ena,
    input  logic                            i_rx_valid,
    input  logic [tlk_link_pkg::WORD_W-1:0] i_rxd,
    input  logic                            i_rk_msb,
    input  logic                            i_rk_lsb,
    tlk_rx_word_if.src                      o_word
);

    logic ena_q;

    // enable is registered, and a drop of the raw enable blocks at once
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_soft_rst) begin
            ena_q        <= 1'b0;
            o_word.valid <= 1'b0;
        end else begin
            ena_q        <= i_check_ena;
            o_word.valid <= i_rx_valid && i_check_ena && ena_q;
        end
    end

    always_ff @(posedge clk) begin
        o_word.data  <= i_rxd;
        o_word.k_msb <= i_rk_msb;
        o_word.k_lsb <= i_rk_lsb;
    end

    // K flags decide sync and SOF/EOF, must be clean on any valid word
    a_k_known: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_word.valid |-> !$isunknown({o_word.k_msb, o_word.k_lsb})
    );

endmodule

//--- hdl/tlk_frame_checker.sv
////////////////////////////////////////////////////////////////////////////
// frame walker for the TLK2711 test frame
// checks each field in turn, flags the first bad one and resyncs in HUNT
// a good EOF gives a frame_ok pulse, events come one cycle after the word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_frame_checker (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_soft_rst,
    input  logic          i_check_ena,
    tlk_rx_word_if.dst    i_word,
    tlk_chk_event_if.src  o_event
);
    import tlk_link_pkg::*;

    chk_state_e        state;
    chk_state_e        nxt_state;
    logic [WORD_W-1:0] w;
    logic [1:0]        kb;
    logic              fail;
    logic              pass;
    err_code_e         fail_code;
    logic              cnt_valid;
    logic [WORD_W-1:0] last_cnt;
    logic [WORD_W-1:0] last_idx;
    logic [WORD_W-1:0] data_idx;
    logic [WORD_W-1:0] csum;

    assign w  = i_word.data;
    assign kb = {i_word.k_msb, i_word.k_lsb};

    ////////////////////////////////////////////////////////////////////////////
    // field checks
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nxt_state = state;
        fail      = 1'b0;
        fail_code = ERR_NONE;
        pass      = 1'b0;
        if (i_word.valid) begin
            case (state)
                HUNT: begin
                    if (w == SYNC_WORD && kb == 2'b01) begin
                        nxt_state = GAP;
                    end
                end
                GAP: begin
                    if (w == SOF_WORD && kb == 2'b11) begin
                        nxt_state = HEAD0;
                    end else if (w != SYNC_WORD || kb != 2'b01) begin
                        fail      = 1'b1;
                        fail_code = ERR_SYNC;
                    end
                end
                HEAD0: begin
                    nxt_state = HEAD1;
                    fail      = (w != HEAD0_WORD) || (kb != 2'b00);
                    fail_code = ERR_HEAD0;
                end
                HEAD1: begin
                    nxt_state = FILEEND;
                    fail      = (w != HEAD1_WORD) || (kb != 2'b00);
                    fail_code = ERR_HEAD1;
                end
                FILEEND: begin
                    nxt_state = FRAME_CNT;
                    fail      = (w != FILEEND_WORD) || (kb != 2'b00);
                    fail_code = ERR_FILEEND;
                end
                FRAME_CNT: begin
                    // first frame after a resync takes any count
                    nxt_state = LENGTH;
                    fail      = (kb != 2'b00) || (cnt_valid && w != last_cnt + 1'b1);
                    fail_code = ERR_FRAME_CNT;
                end
                LENGTH: begin
                    nxt_state = DATA;
                    fail      = (kb != 2'b00) || w[0] || (w == '0) || (w > MAX_LEN_BYTES);
                    fail_code = ERR_LENGTH;
                end
                DATA: begin
                    nxt_state = (data_idx == last_idx) ? CHECKSUM : DATA;
                    fail      = (kb != 2'b00) || (w != data_idx);
                    fail_code = ERR_DATA;
                end
                CHECKSUM: begin
                    nxt_state = EOF;
                    fail      = (kb != 2'b00) || (w != csum);
                    fail_code = ERR_CHECKSUM;
                end
                EOF: begin
                    nxt_state = GAP;
                    pass      = (w == EOF_WORD) && (kb == 2'b11);
                    fail      = !pass;
                    fail_code = ERR_EOF;
                end
                default: begin
                    nxt_state = HUNT;
                end
            endcase
        end
        if (fail) begin
            nxt_state = HUNT;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_soft_rst || !i_check_ena) begin
            state            <= HUNT;
            cnt_valid        <= 1'b0;
            o_event.ev_valid <= 1'b0;
            o_event.frame_ok <= 1'b0;
        end else begin
            state            <= nxt_state;
            o_event.ev_valid <= fail;
            o_event.frame_ok <= pass;
            if (fail) begin
                cnt_valid <= 1'b0;
            end else if (pass) begin
                cnt_valid <= 1'b1;
            end
        end
    end

    // running sum, data index and frame count
    always_ff @(posedge clk) begin
        o_event.ev_code <= fail_code;
        if (pass) begin
            o_event.frame_num <= last_cnt;
        end
        if (i_word.valid) begin
            case (state)
                GAP: begin
                    csum <= '0;
                end
                FILEEND: begin
                    csum <= csum + w;
                end
                FRAME_CNT: begin
                    csum     <= csum + w;
                    last_cnt <= w;
                end
                LENGTH: begin
                    csum     <= csum + w;
                    last_idx <= {1'b0, w[WORD_W-1:1]} - 1'b1;
                    data_idx <= '0;
                end
                DATA: begin
                    csum     <= csum + w;
                    data_idx <= data_idx + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    a_one_pulse: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !(o_event.ev_valid && o_event.frame_ok)
    );

    a_state_legal: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        state inside {HUNT, GAP, HEAD0, HEAD1, FILEEND, FRAME_CNT, LENGTH, DATA, CHECKSUM, EOF}
    );

endmodule

//--- hdl/tlk_error_reporter.sv
////////////////////////////////////////////////////////////////////////////
// output stage of the link checker
// sticky error flag with first error code, good-frame and error counters
// everything holds until soft reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_error_reporter (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic                           i_soft_rst,
    tlk_chk_event_if.dst                   i_event,
    output logic                           o_check_error,
    output tlk_link_pkg::err_code_e        o_error_status,
    output logic [tlk_link_pkg::CNT_W-1:0] o_frame_count,
    output logic [tlk_link_pkg::CNT_W-1:0] o_error_count
);
    import tlk_link_pkg::*;

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_soft_rst) begin
            o_check_error  <= 1'b0;
            o_error_status <= ERR_NONE;
            o_frame_count  <= '0;
            o_error_count  <= '0;
        end else begin
            if (i_event.ev_valid) begin
                // only the first code is kept
                if (!o_check_error) begin
                    o_check_error  <= 1'b1;
                    o_error_status <= i_event.ev_code;
                end
                if (o_error_count != '1) begin
                    o_error_count <= o_error_count + 1'b1;
                end
            end
            if (i_event.frame_ok) begin
                o_frame_count <= o_frame_count + 1'b1;
            end
        end
    end

    a_status_set: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_check_error |-> (o_error_status != ERR_NONE)
    );

    // count of a good frame was captured in the checker before EOF
    a_frame_num_known: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_event.frame_ok |-> !$isunknown(i_event.frame_num)
    );

endmodule

//--- hdl/tlk_rx_link_check.sv
////////////////////////////////////////////////////////////////////////////
// top of the TLK2711 receive-side link checker
// capture, frame walker and reporter in a chain, three cycles in to out
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tlk_rx_link_check (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_soft_rst,
    input  logic                            i_check_ena,
    input  logic                            i_rx_valid,
    input  logic [tlk_link_pkg::WORD_W-1:0] i_rxd,
    input  logic                            i_rk_msb,
    input  logic                            i_rk_lsb,
    output logic                            o_check_error,
    output tlk_link_pkg::err_code_e         o_error_status,
    output logic [tlk_link_pkg::CNT_W-1:0]  o_frame_count,
    output logic [tlk_link_pkg::CNT_W-1:0]  o_error_count
);

    tlk_rx_word_if   rx_word ();
    tlk_chk_event_if chk_event ();

    tlk_rx_capture u_capture (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_soft_rst  (i_soft_rst),
        .i_check_ena (i_check_ena),
        .i_rx_valid  (i_rx_valid),
        .i_rxd       (i_rxd),
        .i_rk_msb    (i_rk_msb),
        .i_rk_lsb    (i_rk_lsb),
        .o_word      (rx_word.src)
    );

    tlk_frame_checker u_checker (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_soft_rst  (i_soft_rst),
        .i_check_ena (i_check_ena),
        .i_word      (rx_word.dst),
        .o_event     (chk_event.src)
    );

    tlk_error_reporter u_reporter (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_soft_rst     (i_soft_rst),
        .i_event        (chk_event.dst),
        .o_check_error  (o_check_error),
        .o_error_status (o_error_status),
        .o_frame_count  (o_frame_count),
        .o_error_count  (o_error_count)
    );

endmodule

//--- dv/tlk_frame_tasks.svh
////////////////////////////////////////////////////////////////////////////
// frame stimulus, wait and compare tasks for the link checker testbench
// included inside the testbench module and uses its signals and seed
////////////////////////////////////////////////////////////////////////////

`ifndef TLK_FRAME_TASKS_SVH
`define TLK_FRAME_TASKS_SVH

task automatic send_word(input logic [WORD_W-1:0] data, input logic [1:0] k);
    @(posedge clk);
    i_rx_valid           <= 1'b1;
    i_rxd                <= data;
    {i_rk_msb, i_rk_lsb} <= k;
endtask

task automatic send_sync(input int count);
    repeat (count) begin
        send_word(SYNC_WORD, 2'b01);
    end
endtask

// bad picks the field to corrupt, ERR_NONE sends a clean frame
task automatic send_frame(input logic [WORD_W-1:0] num, input logic [WORD_W-1:0] len,
                          input err_code_e bad);
    logic [31:0]       rnd;
    logic [WORD_W-1:0] flip;
    logic [WORD_W-1:0] sum;
    logic [WORD_W-1:0] word;
    logic [WORD_W-1:0] idx;
    rnd  = $random(seed);
    flip = {rnd[15:1], 1'b1};
    send_sync(1);
    if (bad == ERR_SYNC) begin
        send_word(flip, 2'b00);
    end
    send_word(SOF_WORD, 2'b11);
    send_word((bad == ERR_HEAD0) ? HEAD0_WORD ^ flip : HEAD0_WORD, 2'b00);
    send_word((bad == ERR_HEAD1) ? HEAD1_WORD ^ flip : HEAD1_WORD, 2'b00);
    send_word((bad == ERR_FILEEND) ? FILEEND_WORD ^ flip : FILEEND_WORD, 2'b00);
    send_word(num, 2'b00);
    send_word(len, 2'b00);
    sum = FILEEND_WORD + num + len;
    for (idx = '0; idx < (len >> 1); idx++) begin
        word = (bad == ERR_DATA && idx == 16'd3) ? idx ^ flip : idx;
        sum  = sum + word;
        send_word(word, 2'b00);
    end
    send_word((bad == ERR_CHECKSUM) ? sum ^ flip : sum, 2'b00);
    send_word(EOF_WORD, (bad == ERR_EOF) ? 2'b10 : 2'b11);
    // bus idles on sync words between frames
    send_sync(1);
endtask

// room for the last word to pass the three register stages
task automatic wait_idle();
    int n;
    for (n = 0; n <= PIPE_LAT; n++) begin
        @(negedge clk);
    end
endtask

task automatic wait_counts(input logic [CNT_W-1:0] frames, input logic [CNT_W-1:0] errors);
    int n;
    n = 0;
    while ((o_frame_count !== frames || o_error_count !== errors) && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (o_frame_count !== frames || o_error_count !== errors) begin
        stop_on_failure("timeout: frame and error counts never reached the expected values");
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        stop_on_failure($sformatf("mismatch at %0t: %s expected %0b got %0b",
                                  $time, what, exp, act));
    end
endtask

task automatic check_code(input string what, input err_code_e exp, input err_code_e act);
    if (act !== exp) begin
        stop_on_failure($sformatf("mismatch at %0t: %s expected %s got %s",
                                  $time, what, exp.name(), act.name()));
    end
endtask

task automatic check_count(input string what, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
    if (act !== exp) begin
        stop_on_failure($sformatf("mismatch at %0t: %s expected %0d got %0d",
                                  $time, what, exp, act));
    end
endtask

task automatic check_all(input logic flag, input err_code_e code,
                         input logic [CNT_W-1:0] frames, input logic [CNT_W-1:0] errors);
    check_flag("error flag", flag, o_check_error);
    check_code("error status", code, o_error_status);
    check_count("frame count", frames, o_frame_count);
    check_count("error count", errors, o_error_count);
endtask

`endif

//--- dv/tb_tlk_rx_link_check.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the TLK2711 receive-side link checker
// directed frame tests driven through the top-level ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_tlk_rx_link_check;
    import tlk_link_pkg::*;

    localparam int WAIT_LIMIT = 2000;
    localparam int PIPE_LAT   = 3;

    logic              clk;
    logic              i_rst_n;
    logic              i_soft_rst;
    logic              i_check_ena;
    logic              i_rx_valid;
    logic [WORD_W-1:0] i_rxd;
    logic              i_rk_msb;
    logic              i_rk_lsb;
    logic              o_check_error;
    err_code_e         o_error_status;
    logic [CNT_W-1:0]  o_frame_count;
    logic [CNT_W-1:0]  o_error_count;
    integer            seed;

    tlk_rx_link_check u_dut (.*);

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopped at the first failure");
    endtask

    `include "tlk_frame_tasks.svh"

    task automatic soft_reset_clear();
        @(posedge clk);
        i_soft_rst <= 1'b1;
        @(posedge clk);
        i_soft_rst <= 1'b0;
        wait_idle();
        check_all(1'b0, ERR_NONE, '0, '0);
    endtask

    // one frame from a clean start with its count taken as is
    task automatic expect_error(input logic [WORD_W-1:0] len, input err_code_e bad,
                                input err_code_e code);
        soft_reset_clear();
        send_frame(16'd9, len, bad);
        wait_counts('0, 16'd1);
        check_all(1'b1, code, '0, 16'd1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_good_frames();
        logic [WORD_W-1:0] num;
        logic [31:0]       rnd;
        send_sync(4);
        for (num = 16'd5; num <= 16'd7; num++) begin
            rnd = $random(seed);
            send_frame(num, {9'd0, rnd[5:0], 1'b0} + 16'd2, ERR_NONE);
        end
        wait_counts(16'd3, '0);
        wait_idle();
        check_all(1'b0, ERR_NONE, 16'd3, '0);
    endtask

    task automatic test_bad_data();
        send_frame(16'd8, 16'd16, ERR_DATA);
        wait_counts(16'd3, 16'd1);
        check_all(1'b1, ERR_DATA, 16'd3, 16'd1);
        send_frame(16'd100, 16'd8, ERR_NONE);
        wait_counts(16'd4, 16'd1);
    endtask

    task automatic test_checksum_and_count();
        send_frame(16'd101, 16'd10, ERR_CHECKSUM);
        send_frame(16'd300, 16'd10, ERR_NONE);
        send_frame(16'd302, 16'd10, ERR_NONE);
        wait_counts(16'd5, 16'd3);
        check_all(1'b1, ERR_DATA, 16'd5, 16'd3);
        expect_error(16'd12, ERR_CHECKSUM, ERR_CHECKSUM);
        soft_reset_clear();
        send_frame(16'd500, 16'd12, ERR_NONE);
        send_frame(16'd502, 16'd12, ERR_NONE);
        wait_counts(16'd1, 16'd1);
        check_all(1'b1, ERR_FRAME_CNT, 16'd1, 16'd1);
    endtask

    task automatic test_length_and_eof();
        expect_error(16'd0, ERR_NONE, ERR_LENGTH);
        expect_error(16'd7, ERR_NONE, ERR_LENGTH);
        expect_error(MAX_LEN_BYTES + 16'd2, ERR_NONE, ERR_LENGTH);
        expect_error(16'd6, ERR_EOF, ERR_EOF);
    endtask

    task automatic test_sync_and_header();
        expect_error(16'd4, ERR_SYNC, ERR_SYNC);
        expect_error(16'd4, ERR_HEAD0, ERR_HEAD0);
        expect_error(16'd4, ERR_HEAD1, ERR_HEAD1);
        expect_error(16'd4, ERR_FILEEND, ERR_FILEEND);
    endtask

    task automatic test_disabled_check();
        send_frame(16'd40, 16'd6, ERR_NONE);
        wait_counts(16'd1, 16'd1);
        @(posedge clk);
        i_check_ena <= 1'b0;
        send_frame(16'd41, 16'd6, ERR_DATA);
        send_frame(16'd43, 16'd6, ERR_HEAD1);
        wait_idle();
        check_all(1'b1, ERR_FILEEND, 16'd1, 16'd1);
        @(posedge clk);
        i_check_ena <= 1'b1;
        soft_reset_clear();
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        seed        = 32'h9965_2b71;
        i_rst_n     = 1'b0;
        i_soft_rst  = 1'b0;
        i_check_ena = 1'b1;
        i_rx_valid  = 1'b0;
        i_rxd       = '0;
        i_rk_msb    = 1'b0;
        i_rk_lsb    = 1'b0;
        repeat (16) @(posedge clk);
        i_rst_n <= 1'b1;
        wait_idle();
        test_good_frames();
        test_bad_data();
        test_checksum_and_count();
        test_length_and_eof();
        test_sync_and_header();
        test_disabled_check();
        $display("No errors");
        $finish;
    end

endmodule

//--- tlk_rx_link_check.f
+incdir+dv
hdl/tlk_link_pkg.sv
hdl/tlk_rx_word_if.sv
hdl/tlk_rx_capture.sv
hdl/tlk_frame_checker.sv
hdl/tlk_error_reporter.sv
hdl/tlk_rx_link_check.sv
dv/tb_tlk_rx_link_check.sv

//--- run_sim.sh
#!/bin/sh
# build and run the link checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_tlk_rx_link_check \
    -f tlk_rx_link_check.f

./obj_dir/Vtb_tlk_rx_link_check
